// ==== hw/cpu_isa_pkg.sv ====
// Instruction encoding of the 16-bit core, shared by RTL and testbench
// Opcodes 7 to 15 are reserved and carry no register or flag effects
`default_nettype none

package cpu_isa_pkg;

	localparam int WORD_BITS   = 16;
	localparam int OPCODE_BITS = 4;
	localparam int REG_BITS    = 4;

	// Field positions inside an instruction word
	localparam int OPCODE_LSB  = 12;
	localparam int DEST_LSB    = 8;
	localparam int SRC_A_LSB   = 4;
	localparam int IMM_LO_LSB  = 0;
	localparam int IMM_LO_BITS = 4;

	// op_imm carries the high prefix in bits 11 to 0
	localparam int IMM_HI_LSB  = 0;
	localparam int IMM_HI_BITS = 12;

	typedef logic [WORD_BITS-1:0] word_t;

	typedef enum logic [OPCODE_BITS-1:0] {
		op_nop         = 4'd0,
		op_alu         = 4'd1,
		op_alu_noflags = 4'd2,
		op_load        = 4'd3,
		op_store       = 4'd4,
		op_branch      = 4'd5,
		op_imm         = 4'd6
	} opcode_e;

	// r0 doubles as the "no destination" tag
	typedef enum logic [REG_BITS-1:0] {
		r0, r1, r2, r3, r4, r5, r6, r7,
		r8, r9, r10, r11, r12, r13, r14, r15
	} reg_e;

	localparam word_t NOP_INSTRUCTION = '0;

endpackage

`default_nettype wire

// ==== hw/cpu_pipe_pkg.sv ====
// Pipeline state encoding and fetch path widths
// PC counts 16-bit words, so byte addresses are twice the PC
`default_nettype none

package cpu_pipe_pkg;

	localparam int PC_BITS   = 15;
	localparam int LINE_BITS = 32;

	// Cache line: fetched word at the bottom, its word address at the top
	localparam int LINE_WORD_LSB = 0;
	localparam int LINE_ADDR_LSB = 17;

	typedef logic [PC_BITS-1:0] pc_t;

	typedef enum logic [3:0] {
		st_halt        = 4'd0,
		st_execute     = 4'd1,
		st_wait_cache1 = 4'd2,
		st_wait_cache2 = 4'd3,
		st_stall_2     = 4'd4,
		st_stall_3     = 4'd5,
		st_stall_4     = 4'd6,
		st_mem_stall1  = 4'd7,
		st_mem_stall2  = 4'd8
	} pipe_state_e;

endpackage

`default_nettype wire

// ==== hw/pipeline_control.sv ====
// Front end FSM: advance, register stall, cache wait, memory freeze or halt
// A failed data memory access wins over every other event while executing
`timescale 1ns/10ps
`default_nettype none

module pipeline_control import cpu_pipe_pkg::*; (
	input  wire         CLK,
	input  wire         RSTb,
	input  wire         halt,
	input  wire         interrupt,
	input  wire         hazard_1,
	input  wire         hazard_2,
	input  wire         cache_miss,
	input  wire         data_memory_was_requested,
	input  wire         data_memory_success,
	input  wire         bank_switch,
	output pipe_state_e state,
	output pipe_state_e prev_state,
	output logic        any_stall_cause,
	output logic        is_executing,
	output logic        wake
);

	pipe_state_e next_state;
	logic        mem_fail;

	assign mem_fail        = data_memory_was_requested && !data_memory_success;
	assign any_stall_cause = mem_fail || hazard_1 || hazard_2 || cache_miss;

	// Cache waits and register stalls still count as executing
	assign is_executing = !(state inside {st_halt, st_mem_stall1, st_mem_stall2});

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state      <= st_execute;
			// Reset counts as a state change, first fetch slot is a NOP
			prev_state <= st_halt;
			wake       <= 1'b0;
		end else begin
			state      <= next_state;
			prev_state <= state;
			wake       <= interrupt;
		end
	end

	always_comb begin
		next_state = state;

		case (state)
			st_halt: begin
				if (wake)
					next_state = st_execute;
			end
			st_execute: begin
				if (hazard_1)
					next_state = st_stall_3;
				else if (hazard_2)
					next_state = st_stall_4;
				else if (cache_miss)
					next_state = st_wait_cache1;
				else if (halt)
					next_state = st_halt;
			end
			// PC is being rewound here
			st_wait_cache1: next_state = st_wait_cache2;
			st_wait_cache2: begin
				if (!cache_miss)
					next_state = st_execute;
			end
			st_stall_2: next_state = st_stall_3;
			st_stall_3: next_state = st_stall_4;
			st_stall_4: next_state = st_execute;
			st_mem_stall1: next_state = st_mem_stall2;
			st_mem_stall2: begin
				if (!bank_switch)
					next_state = st_execute;
			end
			default: next_state = st_execute;
		endcase

		// Memory stall overrides from any executing state
		if (mem_fail && is_executing)
			next_state = st_mem_stall1;
	end

endmodule

`default_nettype wire

// ==== hw/pc_unit.sv ====
// Fetch PC with a one-deep rewind register
// A branch load wins over every state; the fetch after it is masked
`timescale 1ns/10ps
`default_nettype none

module pc_unit import cpu_isa_pkg::*; import cpu_pipe_pkg::*; (
	input  wire         CLK,
	input  wire         RSTb,
	input  wire pipe_state_e state,
	input  wire         any_stall_cause,
	input  wire         load_pc,
	input  wire word_t  new_pc,
	output pc_t         pc,
	output pc_t         pc_prev,
	output logic        load_pc_r
);

	pc_t pc_next;
	pc_t pc_prev_next;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			pc        <= '0;
			pc_prev   <= '0;
			load_pc_r <= 1'b0;
		end else begin
			pc        <= pc_next;
			pc_prev   <= pc_prev_next;
			load_pc_r <= load_pc;
		end
	end

	always_comb begin
		pc_next      = pc;
		pc_prev_next = pc;

		case (state)
			st_execute: begin
				if (any_stall_cause) begin
					pc_next      = pc_prev;
					pc_prev_next = pc_prev;
				end else if (!load_pc_r) begin
					pc_next = pc + 1'b1;
				end
				// Masked slot refetches the branch target next cycle
			end
			// Halt also rewinds, so the word already in stage 0 is not fetched twice
			st_wait_cache1, st_mem_stall1, st_halt: begin
				pc_next      = pc_prev;
				pc_prev_next = pc_prev;
			end
			default: ;
		endcase

		// Byte address to word address
		if (load_pc)
			pc_next = new_pc[WORD_BITS-1:1];
	end

endmodule

`default_nettype wire

// ==== hw/pipeline_regs.sv ====
// Stage 0 to 4 instruction, PC and hazard-tag registers
// Stage PCs hold the address of the following word; pc_stage4 is in bytes
`timescale 1ns/10ps
`default_nettype none

module pipeline_regs import cpu_isa_pkg::*; import cpu_pipe_pkg::*; (
	input  wire         CLK,
	input  wire         RSTb,
	input  wire pipe_state_e state,
	input  wire pipe_state_e prev_state,
	input  wire         load_pc,
	input  wire         load_pc_r,
	input  wire word_t  new_pc,
	input  wire [LINE_BITS-1:0] cache_line,
	input  wire         cache_miss,
	input  wire pc_t    pc,
	input  wire pc_t    pc_prev,
	input  wire reg_e   hazard_reg0,
	input  wire         modifies_flags0,
	output word_t       stage0,
	output word_t       stage1,
	output word_t       stage2,
	output word_t       stage3,
	output word_t       stage4,
	output word_t       pc_stage4,
	output reg_e        hazard_reg1,
	output reg_e        hazard_reg2,
	output reg_e        hazard_reg3,
	output logic        modifies_flags1,
	output logic        modifies_flags2,
	output logic        modifies_flags3
);

	word_t ins_q [0:4];
	word_t ins_d [0:4];
	pc_t   pc_q  [0:4];
	pc_t   pc_d  [0:4];
	reg_e  tag_q [1:3];
	reg_e  tag_d [1:3];
	logic  flg_q [1:3];
	logic  flg_d [1:3];
	logic  fetch_ok;
	pc_t   target;

	// No fetch on a miss, after a state change or in the slot after a branch
	assign fetch_ok = !cache_miss && (state == prev_state) && !load_pc_r;
	assign target   = new_pc[WORD_BITS-1:1];

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			for (int i = 0; i < 5; i++) begin
				ins_q[i] <= NOP_INSTRUCTION;
				pc_q[i]  <= '0;
			end
			for (int i = 1; i < 4; i++) begin
				tag_q[i] <= r0;
				flg_q[i] <= 1'b0;
			end
		end else begin
			ins_q <= ins_d;
			pc_q  <= pc_d;
			tag_q <= tag_d;
			flg_q <= flg_d;
		end
	end

	always_comb begin
		ins_d = ins_q;
		pc_d  = pc_q;
		tag_d = tag_q;
		flg_d = flg_q;

		case (state)
			st_execute: begin
				if (fetch_ok) begin
					ins_d[0] = cache_line[LINE_WORD_LSB +: WORD_BITS];
					pc_d[0]  = cache_line[LINE_ADDR_LSB +: PC_BITS] + 1'b1;
				end else begin
					ins_d[0] = NOP_INSTRUCTION;
					pc_d[0]  = pc;
				end
				for (int i = 1; i < 5; i++) begin
					ins_d[i] = ins_q[i-1];
					pc_d[i]  = pc_q[i-1];
				end
				tag_d[1] = hazard_reg0;
				flg_d[1] = modifies_flags0;
				for (int i = 2; i < 4; i++) begin
					tag_d[i] = tag_q[i-1];
					flg_d[i] = flg_q[i-1];
				end
			end
			// Stage 1 holds, bubble into stage 2, older stages drain
			st_wait_cache1, st_wait_cache2, st_stall_2, st_stall_3, st_stall_4: begin
				ins_d[0] = NOP_INSTRUCTION;
				pc_d[0]  = pc_prev;
				ins_d[2] = NOP_INSTRUCTION;
				pc_d[2]  = pc_q[1];
				tag_d[2] = r0;
				flg_d[2] = 1'b0;
				for (int i = 3; i < 5; i++) begin
					ins_d[i] = ins_q[i-1];
					pc_d[i]  = pc_q[i-1];
				end
				tag_d[3] = tag_q[2];
				flg_d[3] = flg_q[2];
			end
			// Frozen, except the word fetched in the failing cycle is refetched later
			st_mem_stall1, st_mem_stall2: begin
				ins_d[0] = NOP_INSTRUCTION;
				pc_d[0]  = pc_prev;
			end
			default: ;
		endcase

		// Branch flushes the young stages, stages 3 and 4 keep their result
		if (load_pc) begin
			for (int i = 0; i < 3; i++) begin
				ins_d[i] = NOP_INSTRUCTION;
				pc_d[i]  = target;
			end
			for (int i = 1; i < 3; i++) begin
				tag_d[i] = r0;
				flg_d[i] = 1'b0;
			end
		end
	end

	assign stage0    = ins_q[0];
	assign stage1    = ins_q[1];
	assign stage2    = ins_q[2];
	assign stage3    = ins_q[3];
	assign stage4    = ins_q[4];
	assign pc_stage4 = {pc_q[4], 1'b0};

	assign hazard_reg1     = tag_q[1];
	assign hazard_reg2     = tag_q[2];
	assign hazard_reg3     = tag_q[3];
	assign modifies_flags1 = flg_q[1];
	assign modifies_flags2 = flg_q[2];
	assign modifies_flags3 = flg_q[3];

endmodule

`default_nettype wire

// ==== hw/hazard_detect.sv ====
// Combinational register and flag hazard check for the stage 0 word
// Tag r0 never raises a register hazard
`timescale 1ns/10ps
`default_nettype none

module hazard_detect import cpu_isa_pkg::*; (
	input  wire word_t stage0,
	input  wire reg_e  hazard_reg1,
	input  wire reg_e  hazard_reg2,
	input  wire        modifies_flags1,
	input  wire        modifies_flags2,
	output logic       hazard_1,
	output logic       hazard_2,
	output reg_e       hazard_reg0,
	output logic       modifies_flags0
);

	opcode_e op;
	reg_e    dest;
	reg_e    src_a;
	logic    reads_a;
	logic    reads_dest;
	logic    reads_flags;

	assign op    = opcode_e'(stage0[OPCODE_LSB +: OPCODE_BITS]);
	assign dest  = reg_e'(stage0[DEST_LSB +: REG_BITS]);
	assign src_a = reg_e'(stage0[SRC_A_LSB +: REG_BITS]);

	function automatic logic clash(input reg_e tag, input logic flag_writer);
		logic reg_hit;
		reg_hit = (tag != r0) &&
			((reads_a && (src_a == tag)) || (reads_dest && (dest == tag)));
		return reg_hit || (reads_flags && flag_writer);
	endfunction

	always_comb begin
		reads_a         = 1'b0;
		reads_dest      = 1'b0;
		reads_flags     = 1'b0;
		hazard_reg0     = r0;
		modifies_flags0 = 1'b0;

		case (op)
			// Two-address ALU, destination is also an operand
			op_alu: begin
				hazard_reg0     = dest;
				modifies_flags0 = 1'b1;
				reads_a         = 1'b1;
				reads_dest      = 1'b1;
				reads_flags     = 1'b1;
			end
			op_alu_noflags: begin
				hazard_reg0 = dest;
				reads_a     = 1'b1;
				reads_dest  = 1'b1;
			end
			op_load: begin
				hazard_reg0 = dest;
				reads_a     = 1'b1;
			end
			// Store data comes from the destination field
			op_store: begin
				reads_a    = 1'b1;
				reads_dest = 1'b1;
			end
			op_branch: begin
				reads_a     = 1'b1;
				reads_flags = 1'b1;
			end
			default: ;
		endcase

		hazard_1 = clash(hazard_reg1, modifies_flags1);
		hazard_2 = clash(hazard_reg2, modifies_flags2);
	end

endmodule

`default_nettype wire

// ==== hw/imm_builder.sv ====
// Immediate prefix register and the stage 2 immediate
// Prefix survives NOPs only; a branch or any other instruction clears it
`timescale 1ns/10ps
`default_nettype none

module imm_builder import cpu_isa_pkg::*; import cpu_pipe_pkg::*; (
	input  wire         CLK,
	input  wire         RSTb,
	input  wire pipe_state_e prev_state,
	input  wire         load_pc,
	input  wire word_t  stage1,
	output word_t       imm_reg
);

	logic [IMM_HI_BITS-1:0] prefix;
	logic [IMM_HI_BITS-1:0] prefix_next;
	opcode_e                op1;

	assign op1 = opcode_e'(stage1[OPCODE_LSB +: OPCODE_BITS]);

	always_comb begin
		// A flushed op_imm must not leak into the branch target
		if (load_pc)
			prefix_next = '0;
		else if (op1 == op_imm)
			prefix_next = stage1[IMM_HI_LSB +: IMM_HI_BITS];
		else if (stage1 == NOP_INSTRUCTION)
			prefix_next = prefix;
		else
			prefix_next = '0;
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			prefix  <= '0;
			imm_reg <= '0;
		end else begin
			prefix <= prefix_next;
			// Only once per stage 1 word, stalls leave it alone
			if (prev_state == st_execute)
				imm_reg <= {prefix, stage1[IMM_LO_LSB +: IMM_LO_BITS]};
		end
	end

endmodule

`default_nettype wire

// ==== hw/cpu_frontend.sv ====
// Instruction front end of the 16-bit core, five stages
// Cache and data memory are external; cache answers in the same cycle
`timescale 1ns/10ps
`default_nettype none

module cpu_frontend import cpu_isa_pkg::*; import cpu_pipe_pkg::*; (
	input  wire         CLK,
	input  wire         RSTb,
	input  wire         load_pc,
	input  wire word_t  new_pc,
	input  wire         halt,
	input  wire         interrupt,
	input  wire         data_memory_was_requested,
	input  wire         data_memory_success,
	input  wire         bank_switch,
	input  wire [LINE_BITS-1:0] cache_line,
	input  wire         cache_miss,
	output word_t       stage0,
	output word_t       stage1,
	output word_t       stage2,
	output word_t       stage3,
	output word_t       stage4,
	output word_t       pc_stage4,
	output word_t       imm_reg,
	output logic        is_executing,
	output logic        wake,
	output pc_t         cache_request_address
);

	pipe_state_e state;
	pipe_state_e prev_state;
	logic        any_stall_cause;
	logic        hazard_1;
	logic        hazard_2;
	reg_e        hazard_reg0;
	reg_e        hazard_reg1;
	reg_e        hazard_reg2;
	logic        modifies_flags0;
	logic        modifies_flags1;
	logic        modifies_flags2;
	pc_t         pc;
	pc_t         pc_prev;
	logic        load_pc_r;

	assign cache_request_address = pc;

	pipeline_control i_ctrl (
		.CLK, .RSTb, .halt, .interrupt, .hazard_1, .hazard_2, .cache_miss,
		.data_memory_was_requested, .data_memory_success, .bank_switch,
		.state, .prev_state, .any_stall_cause, .is_executing, .wake
	);

	pc_unit i_pc (
		.CLK, .RSTb, .state, .any_stall_cause, .load_pc, .new_pc,
		.pc, .pc_prev, .load_pc_r
	);

	// Stage 3 tags serve the execute stage, not used inside the front end
	pipeline_regs i_regs (
		.CLK, .RSTb, .state, .prev_state, .load_pc, .load_pc_r, .new_pc,
		.cache_line, .cache_miss, .pc, .pc_prev, .hazard_reg0, .modifies_flags0,
		.stage0, .stage1, .stage2, .stage3, .stage4, .pc_stage4,
		.hazard_reg1, .hazard_reg2, .hazard_reg3(),
		.modifies_flags1, .modifies_flags2, .modifies_flags3()
	);

	hazard_detect i_hazard (
		.stage0, .hazard_reg1, .hazard_reg2, .modifies_flags1, .modifies_flags2,
		.hazard_1, .hazard_2, .hazard_reg0, .modifies_flags0
	);

	imm_builder i_imm (
		.CLK, .RSTb, .prev_state, .load_pc, .stage1, .imm_reg
	);

endmodule

`default_nettype wire

// ==== tests/cpu_frontend_properties.sv ====
// Concurrent checks on the front end FSM, branch flush and reset values
// Bound to every cpu_frontend instance
`timescale 1ns/10ps
`default_nettype none

module cpu_frontend_properties import cpu_isa_pkg::*; import cpu_pipe_pkg::*; (
	input wire              CLK,
	input wire              RSTb,
	input wire              load_pc,
	input wire              bank_switch,
	input wire word_t       stage0,
	input wire word_t       stage1,
	input wire word_t       stage2,
	input wire              wake,
	input wire pipe_state_e state
);

	// Memory stall only leaves through its own exit
	mem_stall1_exit: assert property (@(posedge CLK) disable iff (!RSTb)
		state == st_mem_stall1 |=> state == st_mem_stall2)
		else $error("mem_stall1 did not move to mem_stall2");

	mem_stall2_hold: assert property (@(posedge CLK) disable iff (!RSTb)
		(state == st_mem_stall2 && bank_switch) |=> state == st_mem_stall2)
		else $error("mem_stall2 left while bank_switch high");

	mem_stall2_exit: assert property (@(posedge CLK) disable iff (!RSTb)
		(state == st_mem_stall2 && !bank_switch) |=> state == st_execute)
		else $error("mem_stall2 did not return to execute");

	// Young stages empty after a branch
	branch_flush: assert property (@(posedge CLK) disable iff (!RSTb)
		load_pc |=> (stage0 == NOP_INSTRUCTION && stage1 == NOP_INSTRUCTION &&
			stage2 == NOP_INSTRUCTION))
		else $error("stages 0 to 2 not flushed after load_pc");

	reset_values: assert property (@(posedge CLK)
		!RSTb |=> (!wake && state == st_execute))
		else $error("wrong wake or state after reset");

endmodule

bind cpu_frontend cpu_frontend_properties i_props (
	.CLK, .RSTb, .load_pc, .bank_switch, .stage0, .stage1, .stage2, .wake, .state
);

`default_nettype wire

// ==== tests/cpu_frontend_tb.sv ====
// Directed tests of the front end with a 64-word cache model
// Addresses from 64 up read as NOP; address 0 of each program is a NOP
`timescale 1ns/10ps
`default_nettype none

module cpu_frontend_tb import cpu_isa_pkg::*; import cpu_pipe_pkg::*; ();

	localparam time CLK_PERIOD  = 100ns;
	localparam int  PROG_WORDS  = 64;
	localparam int  NUM_RUNS    = 7;
	localparam int  WATCHDOG_CYCLES = 40 * PROG_WORDS * NUM_RUNS;

	logic                 CLK;
	logic                 RSTb;
	logic                 load_pc;
	word_t                new_pc;
	logic                 halt;
	logic                 interrupt;
	logic                 data_memory_was_requested;
	logic                 data_memory_success;
	logic                 bank_switch;
	logic [LINE_BITS-1:0] cache_line;
	logic                 cache_miss;
	word_t                stage0;
	word_t                stage1;
	word_t                stage2;
	word_t                stage3;
	word_t                stage4;
	word_t                pc_stage4;
	word_t                imm_reg;
	logic                 is_executing;
	logic                 wake;
	pc_t                  cache_request_address;

	word_t prog [0:PROG_WORDS-1];
	int    exp_q[$];
	int    last_retired;
	logic  prev_exec;
	string test_name;
	int    err_count;
	int    seed;
	pc_t   miss_addr;
	int    miss_left;
	logic  rand_en;
	logic  rand_miss;

	cpu_frontend i_dut (
		.CLK, .RSTb, .load_pc, .new_pc, .halt, .interrupt,
		.data_memory_was_requested, .data_memory_success, .bank_switch,
		.cache_line, .cache_miss, .stage0, .stage1, .stage2, .stage3, .stage4,
		.pc_stage4, .imm_reg, .is_executing, .wake, .cache_request_address
	);

	always #(CLK_PERIOD / 2) CLK = !CLK;

	// Cache answers in the same cycle; word address sits above bit 16
	always_comb begin
		if (cache_request_address < PROG_WORDS)
			cache_line = {cache_request_address, 1'b0, prog[cache_request_address[5:0]]};
		else
			cache_line = {cache_request_address, 1'b0, NOP_INSTRUCTION};
		cache_miss = rand_miss ||
			(miss_left > 0 && cache_request_address == miss_addr);
	end

	task automatic fail_run(input string msg);
		err_count++;
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic compare_word(input string what, input word_t expected, input word_t actual);
		if (expected !== actual)
			fail_run($sformatf("** Error: [%s] %s expected %h actual %h",
				test_name, what, expected, actual));
	endtask

	task automatic compare_state_bit(input string what, input logic expected, input logic actual);
		if (expected !== actual)
			fail_run($sformatf("** Error: [%s] %s expected %b actual %b",
				test_name, what, expected, actual));
	endtask

	function automatic word_t make_word(input opcode_e op, input reg_e dst, input reg_e src,
		input logic [3:0] lo);
		return {op, dst, src, lo};
	endfunction

	// Loads with source r0 never raise a hazard
	task automatic load_straight(input int first, input int last);
		for (int a = first; a <= last; a++) begin
			prog[a] = make_word(op_load, reg_e'(1 + a % 15), r0, a[3:0]);
			exp_q.push_back(a);
		end
	endtask

	task automatic reset_dut(input string name);
		test_name = name;
		RSTb = 1'b0;
		load_pc = 1'b0;
		new_pc = '0;
		halt = 1'b0;
		interrupt = 1'b0;
		data_memory_was_requested = 1'b0;
		data_memory_success = 1'b1;
		bank_switch = 1'b0;
		miss_left = 0;
		rand_en = 1'b0;
		rand_miss = 1'b0;
		prev_exec = 1'b0;
		last_retired = -1;
		exp_q.delete();
		for (int a = 0; a < PROG_WORDS; a++)
			prog[a] = NOP_INSTRUCTION;
		repeat (5) @(negedge CLK);
		RSTb = 1'b1;
	endtask

	// One cycle: check the retiring word, then update the cache model
	task automatic step();
		int a;
		@(negedge CLK);
		if (prev_exec && stage4 != NOP_INSTRUCTION) begin
			if (exp_q.size() == 0)
				fail_run($sformatf("[%s] word %h retired with nothing left to retire",
					test_name, stage4));
			a = exp_q.pop_front();
			compare_word("retired word", prog[a], stage4);
			compare_word("pc_stage4", word_t'((a + 1) * 2), pc_stage4);
			last_retired = a;
		end
		prev_exec = is_executing;
		if (miss_left > 0 && cache_request_address == miss_addr)
			miss_left--;
		rand_miss = rand_en && (($random(seed) & 3) == 0);
	endtask

	task automatic drain();
		while (exp_q.size() > 0)
			step();
		// Trailing NOPs only, any extra retirement is caught here
		repeat (8) step();
	endtask

	task automatic run_until(input int addr);
		while (last_retired != addr)
			step();
	endtask

	task automatic straight_program();
		reset_dut("straight");
		load_straight(1, 20);
		drain();
	endtask

	task automatic hazard_stalls();
		word_t before_word;
		int    before_addr;
		reset_dut("hazards");
		prog[1] = make_word(op_load, r1, r0, 4'h1);
		prog[2] = make_word(op_alu_noflags, r2, r1, 4'h2);
		prog[3] = make_word(op_load, r3, r0, 4'h3);
		prog[4] = make_word(op_load, r4, r0, 4'h4);
		prog[5] = make_word(op_alu_noflags, r5, r3, 4'h5);
		for (int a = 6; a <= 10; a++)
			prog[a] = make_word(op_load, reg_e'(a), r0, a[3:0]);
		prog[11] = make_word(op_alu_noflags, r11, r10, 4'hb);
		for (int a = 1; a <= 11; a++)
			exp_q.push_back(a);
		while (exp_q.size() > 0) begin
			before_word = stage4;
			before_addr = last_retired;
			step();
			compare_state_bit("is_executing", 1'b1, is_executing);
			// A stalled consumer retires behind a bubble
			if (last_retired != before_addr &&
				(last_retired == 2 || last_retired == 5 || last_retired == 11))
				compare_word("stage4 before dependent word", NOP_INSTRUCTION, before_word);
		end
		repeat (8) step();
	endtask

	task automatic cache_misses();
		reset_dut("miss_directed");
		load_straight(1, 30);
		miss_addr = 5;
		miss_left = 3;
		drain();
		reset_dut("miss_random");
		load_straight(1, 30);
		rand_en = 1'b1;
		drain();
	endtask

	task automatic branch_redirect();
		reset_dut("branch");
		load_straight(1, 20);
		load_straight(40, 45);
		run_until(6);
		// Words 7 and 8 sit in stages 3 and 2 and survive the flush
		load_pc = 1'b1;
		new_pc = word_t'(40 * 2);
		exp_q.delete();
		exp_q.push_back(7);
		exp_q.push_back(8);
		for (int a = 40; a <= 45; a++)
			exp_q.push_back(a);
		step();
		load_pc = 1'b0;
		compare_word("stage3 after flush", prog[8], stage3);
		drain();
	endtask

	task automatic freeze_and_halt();
		word_t held;
		reset_dut("freeze_halt");
		load_straight(1, 30);
		run_until(5);
		data_memory_was_requested = 1'b1;
		data_memory_success = 1'b0;
		bank_switch = 1'b1;
		step();
		data_memory_was_requested = 1'b0;
		data_memory_success = 1'b1;
		held = stage4;
		compare_state_bit("is_executing in freeze", 1'b0, is_executing);
		repeat (3) begin
			step();
			compare_word("frozen stage4", held, stage4);
			compare_state_bit("is_executing in freeze", 1'b0, is_executing);
		end
		bank_switch = 1'b0;
		run_until(12);
		halt = 1'b1;
		step();
		halt = 1'b0;
		compare_state_bit("is_executing in halt", 1'b0, is_executing);
		repeat (3) begin
			step();
			compare_state_bit("is_executing in halt", 1'b0, is_executing);
			compare_state_bit("wake in halt", 1'b0, wake);
		end
		interrupt = 1'b1;
		step();
		interrupt = 1'b0;
		compare_state_bit("wake", 1'b1, wake);
		drain();
	endtask

	task automatic immediate_prefix();
		word_t alu_word;
		logic  seen;
		reset_dut("immediate");
		seen = 1'b0;
		alu_word = make_word(op_alu, r1, r0, 4'h5);
		prog[1] = make_word(op_load, r9, r0, 4'h1);
		prog[2] = make_word(op_load, r10, r0, 4'h2);
		prog[3] = {op_imm, 12'habc};
		prog[4] = alu_word;
		prog[5] = make_word(op_load, r11, r0, 4'h5);
		prog[6] = make_word(op_load, r12, r0, 4'h6);
		for (int a = 1; a <= 6; a++)
			exp_q.push_back(a);
		while (exp_q.size() > 0) begin
			step();
			// Prefix joined with the low nibble of the following word
			if (stage2 == alu_word) begin
				compare_word("imm_reg", {12'habc, 4'h5}, imm_reg);
				seen = 1'b1;
			end
		end
		if (!seen)
			fail_run("[immediate] the ALU word never reached stage 2");
		repeat (8) step();
	endtask

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired: the tests did not finish in %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation FAILED");
		$fatal(1, "timeout");
	end

	initial begin
		CLK = 1'b0;
		err_count = 0;
		seed = 40;
		miss_addr = '0;
		straight_program();
		hazard_stalls();
		cache_misses();
		branch_redirect();
		freeze_and_halt();
		immediate_prefix();
		if (err_count == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
hw/cpu_isa_pkg.sv
hw/cpu_pipe_pkg.sv
hw/pipeline_control.sv
hw/pc_unit.sv
hw/pipeline_regs.sv
hw/hazard_detect.sv
hw/imm_builder.sv
hw/cpu_frontend.sv
tests/cpu_frontend_properties.sv
tests/cpu_frontend_tb.sv

// ==== Bender.yml ====
package:
  name: cpu_frontend

sources:
  - hw/cpu_isa_pkg.sv
  - hw/cpu_pipe_pkg.sv
  - hw/pipeline_control.sv
  - hw/pc_unit.sv
  - hw/pipeline_regs.sv
  - hw/hazard_detect.sv
  - hw/imm_builder.sv
  - hw/cpu_frontend.sv
  - target: test
    files:
      - tests/cpu_frontend_properties.sv
      - tests/cpu_frontend_tb.sv
